/* include/acore_config.svh */
`ifndef ACORE_CONFIG_SVH
`define ACORE_CONFIG_SVH

// number of time-interleaved slices, 4, 8 or 16
`define ACORE_NTI 8

// magnitude code width per slice
`define ACORE_NADC 8

// signed input sample width
`define ACORE_NSAMP 9

// signed offset trim width per slice
// keep it narrower than the sample
`define ACORE_NTRIM 5

`endif

/* verilog/acore_pkg.sv */
`include "acore_config.svh"

package acore_pkg;

    // signed sample code from the front end
    typedef logic signed [`ACORE_NSAMP-1:0] sample_t;

    // per-slice offset trim
    typedef logic signed [`ACORE_NTRIM-1:0] trim_t;

    // saturated magnitude out of a slice
    typedef logic [`ACORE_NADC-1:0] code_t;

    // slice number
    typedef logic [$clog2(`ACORE_NTI)-1:0] slice_idx_t;

    // enable-sync sequencing
    typedef enum logic [1:0] {
        IDLE = 2'd0,    // slices asleep
        SYNC = 2'd1,    // chain rippling up
        RUN  = 2'd2     // all slices converting
    } sync_state_t;

endpackage

/* verilog/acore_sync_fsm.sv */
`timescale 1ns/1ns
`include "acore_config.svh"

module acore_sync_fsm (
    input  logic                  clk_in_i,
    input  logic                  rst_i,
    input  logic                  en_v2t_i,     // level enable for the whole core
    output logic [`ACORE_NTI-1:0] en_sync_o,    // one bit per slice
    output logic                  run_o
);

    localparam int NTI = `ACORE_NTI;

    acore_pkg::sync_state_t state_q;
    logic [NTI-1:0]         en_sync_q;

    // the chain ripples in one slice per edge from slice 0 up
    always_ff @(posedge clk_in_i) begin
        if (rst_i) begin
            state_q   <= acore_pkg::IDLE;
            en_sync_q <= '0;
        end else if (!en_v2t_i) begin
            state_q   <= acore_pkg::IDLE;   // enable gone so the chain tears down
            en_sync_q <= '0;
        end else begin
            case (state_q)
                acore_pkg::IDLE: begin
                    state_q   <= acore_pkg::SYNC;
                    en_sync_q <= {{(NTI-1){1'b0}}, 1'b1};
                end
                acore_pkg::SYNC: begin
                    // last slice came up on the previous edge
                    if (&en_sync_q) begin
                        state_q <= acore_pkg::RUN;
                    end
                    en_sync_q <= {en_sync_q[NTI-2:0], 1'b1};
                end
                acore_pkg::RUN: begin
                    state_q <= acore_pkg::RUN;
                end
                default: begin
                    state_q   <= acore_pkg::IDLE;   // unused encoding
                    en_sync_q <= '0;
                end
            endcase
        end
    end

    assign en_sync_o = en_sync_q;
    assign run_o     = (state_q == acore_pkg::RUN);

    // no slice may be converting before its sync bit is up
    a_run_needs_full_chain: assert property (
        @(posedge clk_in_i) disable iff (rst_i)
        run_o |-> (&en_sync_o)
    );

endmodule

/* verilog/slice_counter.sv */
`timescale 1ns/1ns
`include "acore_config.svh"

module slice_counter (
    input  logic                  clk_in_i,
    input  logic                  rst_i,
    input  logic                  run_i,
    output logic [`ACORE_NTI-1:0] slice_sel_o,    // one-hot capture select
    output logic                  last_slice_o
);

    localparam acore_pkg::slice_idx_t LAST = acore_pkg::slice_idx_t'(`ACORE_NTI - 1);

    acore_pkg::slice_idx_t count_q;

    always_ff @(posedge clk_in_i) begin
        if (rst_i) begin
            count_q <= '0;
        end else if (!run_i) begin
            count_q <= '0;                      // parked until run
        end else if (count_q == LAST) begin
            count_q <= '0;
        end else begin
            count_q <= count_q + 1'b1;
        end
    end

    // decode to selects, nothing selected outside run
    always_comb begin
        slice_sel_o = '0;
        if (run_i) begin
            slice_sel_o[count_q] = 1'b1;
        end
    end

    assign last_slice_o = (count_q == LAST);    // retimer qualifies with run

    a_sel_onehot: assert property (
        @(posedge clk_in_i) disable iff (rst_i)
        run_i ? $onehot(slice_sel_o) : (slice_sel_o == '0)
    );

endmodule

/* verilog/adc_slice.sv */
`timescale 1ns/1ns
`include "acore_config.svh"

module adc_slice (
    input  logic                clk_in_i,
    input  logic                rst_i,
    input  logic                capture_i,    // this slice's turn
    input  logic                en_i,         // sync bit and slice enable
    input  acore_pkg::trim_t    trim_i,
    input  acore_pkg::sample_t  sample_i,
    output acore_pkg::code_t    code_o,
    output logic                sign_o
);

    localparam int          SW       = `ACORE_NSAMP + 1;    // room for sample plus trim
    localparam int unsigned CODE_MAX = (1 << `ACORE_NADC) - 1;

    logic signed [SW-1:0] sum;
    logic [SW-1:0]        mag;
    acore_pkg::code_t     code_d;
    logic                 sign_d;

    always_comb begin
        sum = SW'(sample_i) + SW'(trim_i);      // both sign-extended
        mag = sum[SW-1] ? unsigned'(-sum) : unsigned'(sum);

        // clip the magnitude to the code range
        if (32'(mag) > CODE_MAX) begin
            code_d = '1;
        end else begin
            code_d = acore_pkg::code_t'(mag);
        end
        sign_d = ~sum[SW-1];                    // zero counts as positive

        if (!en_i) begin
            code_d = '0;                        // sleeping slice reads as zero
            sign_d = 1'b0;
        end
    end

    // sample and result land on the same edge
    always_ff @(posedge clk_in_i) begin
        if (rst_i) begin
            code_o <= '0;
            sign_o <= 1'b0;
        end else if (capture_i) begin
            code_o <= code_d;
            sign_o <= sign_d;
        end
    end

    // result must hold for the rest of the frame
    a_code_holds: assert property (
        @(posedge clk_in_i) disable iff (rst_i)
        !capture_i |=> $stable(code_o) && $stable(sign_o)
    );

endmodule

/* verilog/frame_retimer.sv */
`timescale 1ns/1ns
`include "acore_config.svh"

module frame_retimer (
    input  logic                  clk_in_i,
    input  logic                  rst_i,
    input  logic                  run_i,
    input  logic                  last_slice_i,
    input  acore_pkg::code_t      slice_code_i [`ACORE_NTI-1:0],
    input  logic [`ACORE_NTI-1:0] slice_sign_i,
    output acore_pkg::code_t      adder_out_o [`ACORE_NTI-1:0],
    output logic [`ACORE_NTI-1:0] sign_out_o,
    output logic                  frame_valid_o
);

    logic last_q;    // last slice was captured on the previous edge
    logic run_q;     // and it was a real run cycle
    logic load;

    assign load = last_q & run_q;

    always_ff @(posedge clk_in_i) begin
        if (rst_i) begin
            last_q        <= 1'b0;
            run_q         <= 1'b0;
            frame_valid_o <= 1'b0;
        end else begin
            last_q        <= last_slice_i;
            run_q         <= run_i;
            frame_valid_o <= load;
        end
    end

    // output bank, holds between frames
    always_ff @(posedge clk_in_i) begin
        if (rst_i) begin
            for (int i = 0; i < `ACORE_NTI; i++) begin
                adder_out_o[i] <= '0;
            end
            sign_out_o <= '0;
        end else if (load) begin
            for (int i = 0; i < `ACORE_NTI; i++) begin
                adder_out_o[i] <= slice_code_i[i];
            end
            sign_out_o <= slice_sign_i;
        end
    end

    // a frame takes at least a full slice rotation
    a_valid_spacing: assert property (
        @(posedge clk_in_i) disable iff (rst_i)
        frame_valid_o |=> !frame_valid_o
    );

endmodule

/* verilog/analog_core.sv */
`timescale 1ns/1ns
`include "acore_config.svh"

module analog_core (
    input  logic                  clk_in_i,
    input  logic                  rst_i,
    input  logic                  en_v2t_i,                        // core enable
    input  logic [`ACORE_NTI-1:0] en_slice_i,                      // per-slice enable
    input  acore_pkg::trim_t      trim_i [`ACORE_NTI-1:0],         // per-slice offset trim
    input  acore_pkg::sample_t    rx_data_i,                       // one sample per clock
    output logic                  run_o,
    output logic                  frame_valid_o,
    output acore_pkg::code_t      adder_out_o [`ACORE_NTI-1:0],    // frame of codes
    output logic [`ACORE_NTI-1:0] sign_out_o
);

    // internal signals
    logic [`ACORE_NTI-1:0] en_sync;
    logic [`ACORE_NTI-1:0] slice_en;
    logic [`ACORE_NTI-1:0] slice_sel;
    logic [`ACORE_NTI-1:0] slice_sign;
    logic                  run;
    logic                  last_slice;
    acore_pkg::code_t      slice_code [`ACORE_NTI-1:0];

    assign run_o = run;

    // wakes the slices in order, then flags run mode
    acore_sync_fsm isync (
        .clk_in_i  (clk_in_i),
        .rst_i     (rst_i),
        .en_v2t_i  (en_v2t_i),
        .en_sync_o (en_sync),
        .run_o     (run)
    );

    slice_counter icnt (
        .clk_in_i     (clk_in_i),
        .rst_i        (rst_i),
        .run_i        (run),
        .slice_sel_o  (slice_sel),
        .last_slice_o (last_slice)
    );

    // interleaved slices, slice k takes every Nti-th sample
    genvar k;
    generate
        for (k = 0; k < `ACORE_NTI; k++) begin : g_adc
            assign slice_en[k] = en_sync[k] & en_slice_i[k];

            adc_slice iadc (
                .clk_in_i  (clk_in_i),
                .rst_i     (rst_i),
                .capture_i (slice_sel[k]),
                .en_i      (slice_en[k]),
                .trim_i    (trim_i[k]),
                .sample_i  (rx_data_i),
                .code_o    (slice_code[k]),
                .sign_o    (slice_sign[k])
            );
        end
    endgenerate

    // stands in for the divided retiming clock
    frame_retimer iretime (
        .clk_in_i      (clk_in_i),
        .rst_i         (rst_i),
        .run_i         (run),
        .last_slice_i  (last_slice),
        .slice_code_i  (slice_code),
        .slice_sign_i  (slice_sign),
        .adder_out_o   (adder_out_o),
        .sign_out_o    (sign_out_o),
        .frame_valid_o (frame_valid_o)
    );

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD = 8    // ns
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

/* bench/analog_core_tb.sv */
`timescale 1ns/1ns
`include "acore_config.svh"

module analog_core_tb;

    localparam int NTI      = `ACORE_NTI;
    localparam int NROWS    = 5;
    localparam int CODE_MAX = (1 << `ACORE_NADC) - 1;
    localparam int SMAX     = (1 << (`ACORE_NSAMP - 1)) - 1;
    localparam int SMIN     = -(1 << (`ACORE_NSAMP - 1));

    logic                     clk;
    logic                     rst;
    logic                     en_v2t;
    logic [NTI-1:0]           en_slice;
    acore_pkg::trim_t         trim [NTI-1:0];
    acore_pkg::sample_t       rx_data;
    logic                     run;
    logic                     frame_valid;
    acore_pkg::code_t         adder_out [NTI-1:0];
    logic [NTI-1:0]           sign_out;

    // test table, one row per test
    string       row_name   [NROWS];
    logic [15:0] row_mask   [NROWS];    // low NTI bits used
    int          row_trim   [NROWS][4]; // slice k gets entry k mod 4
    int          row_mode   [NROWS];    // 0 random, 1 extremes
    int          row_frames [NROWS];
    bit          row_drop   [NROWS];

    logic [31:0] seed;
    int          samp [0:255];
    int          errors, checks, ntests, nfailed;
    int          cycles = 0;
    int          limit = 0;

    tb_clock iclk (.clk_o(clk));

    analog_core UUT (
        .clk_in_i      (clk),
        .rst_i         (rst),
        .en_v2t_i      (en_v2t),
        .en_slice_i    (en_slice),
        .trim_i        (trim),
        .rx_data_i     (rx_data),
        .run_o         (run),
        .frame_valid_o (frame_valid),
        .adder_out_o   (adder_out),
        .sign_out_o    (sign_out)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout, the run did not finish within %0d cycles", limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic set_row(input int r, input string name, input logic [15:0] mask,
                           input int t0, input int t1, input int t2, input int t3,
                           input int mode, input int frames, input bit drop);
        row_name[r]   = name;
        row_mask[r]   = mask;
        row_trim[r][0] = t0;
        row_trim[r][1] = t1;
        row_trim[r][2] = t2;
        row_trim[r][3] = t3;
        row_mode[r]   = mode;
        row_frames[r] = frames;
        row_drop[r]   = drop;
    endtask

    function automatic int lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return int'(seed);
    endfunction

    function automatic int make_sample(input int r, input int j);
        int k;
        k = j % NTI;
        if (row_mode[r] == 0) begin
            return lcg_next() >>> (32 - `ACORE_NSAMP);    // top bits, signed
        end
        case ((j + j / NTI) % 4)    // rotate the pattern from frame to frame
            0: return SMAX;
            1: return SMIN;
            2: return -row_trim[r][k % 4];      // zero sum
            default: return -row_trim[r][k % 4] - 1;
        endcase
    endfunction

    // expected slice output from sample, trim and enable
    function automatic void convert(input int s, input int t, input bit en,
                                    output int code, output int sign);
        int sum;
        sum  = s + t;
        sign = (sum >= 0) ? 1 : 0;
        code = (sum < 0) ? -sum : sum;
        if (code > CODE_MAX) code = CODE_MAX;
        if (!en) begin
            code = 0;
            sign = 0;
        end
    endfunction

    task automatic check_val(input string name, input int exp, input int got);
        checks++;
        if (exp != got) begin
            errors++;
            $display("ERR t=%0t %s expected %0d got %0d", $time, name, exp, got);
        end
    endtask

    // en_v2t low, nothing may come out
    task automatic idle_check(input int n);
        repeat (n) begin
            @(negedge clk);
            check_val("run_o", 0, int'(run));
            check_val("frame_valid_o", 0, int'(frame_valid));
        end
    endtask

    // raise en_v2t and count edges up to run
    task automatic bring_up();
        int n;
        n = 0;
        @(negedge clk);
        en_v2t = 1'b1;
        while (!run && n <= NTI + 4) begin
            @(negedge clk);
            n++;
        end
        check_val("run_o rise edge", NTI + 1, n);
    endtask

    task automatic stream(input int r, input int nframes, input int extra);
        int  i, seen, k, code, sign, stop;
        bit  done;
        i    = 0;
        seen = 0;
        done = 0;
        stop = nframes * NTI + extra + NTI + 4;
        while (!done) begin
            if (frame_valid) begin
                check_val("frame_valid_o cycle", seen * NTI + NTI + 1, i);
                for (k = 0; k < NTI; k++) begin
                    convert(samp[seen * NTI + k], row_trim[r][k % 4], row_mask[r][k],
                            code, sign);
                    check_val($sformatf("adder_out_o[%0d]", k), code, int'(adder_out[k]));
                    check_val($sformatf("sign_out_o[%0d]", k), sign, int'(sign_out[k]));
                end
                seen++;
            end
            if (seen >= nframes && i >= nframes * NTI + extra) begin
                done = 1;
            end else if (i >= stop) begin
                errors++;
                $display("frame_valid_o never arrived for frame %0d of test %0d", seen, r);
                done = 1;
            end else begin
                samp[i] = make_sample(r, i);
                rx_data = acore_pkg::sample_t'(samp[i]);
                i++;
                @(negedge clk);
            end
        end
    endtask

    task automatic report_test(input int id, input string name, input int start);
        ntests++;
        if (errors != start) nfailed++;
        $display("test %0d %s: %s, %0d errors", id, name,
                 (errors == start) ? "pass" : "fail", errors - start);
    endtask

    initial begin
        int r;
        int k;
        int start;
        seed     = 32'hfed22938;
        errors   = 0;
        checks   = 0;
        ntests   = 0;
        nfailed  = 0;
        rst      = 1'b1;
        en_v2t   = 1'b0;
        en_slice = '0;
        rx_data  = '0;
        for (k = 0; k < NTI; k++) trim[k] = '0;

        set_row(0, "random frames", 16'hFFFF, 3, -5, 7, -2, 0, 4, 0);
        set_row(1, "saturation", 16'hFFFF, 15, -16, 15, -16, 1, 2, 0);
        set_row(2, "slice mask", 16'hA5A5, 1, -1, 4, -8, 0, 3, 0);
        set_row(3, "mask with extremes", 16'h3C3C, -16, 15, -9, 12, 1, 2, 0);
        set_row(4, "enable drop", 16'hFFFF, -3, 6, 0, 9, 0, 2, 1);
        for (r = 0; r < NROWS; r++) begin
            limit += (row_frames[r] + int'(row_drop[r])) * (NTI + 2) + 3 * NTI + 50;
        end

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        start = errors;
        @(negedge clk);
        check_val("run_o", 0, int'(run));
        check_val("frame_valid_o", 0, int'(frame_valid));
        for (k = 0; k < NTI; k++) begin
            check_val($sformatf("adder_out_o[%0d]", k), 0, int'(adder_out[k]));
            check_val($sformatf("sign_out_o[%0d]", k), 0, int'(sign_out[k]));
        end
        idle_check(4);
        report_test(0, "reset and idle", start);

        for (r = 0; r < NROWS; r++) begin
            start    = errors;
            en_v2t   = 1'b0;
            en_slice = row_mask[r][NTI-1:0];
            for (k = 0; k < NTI; k++) trim[k] = acore_pkg::trim_t'(row_trim[r][k % 4]);
            idle_check(2);
            bring_up();
            stream(r, row_frames[r], row_drop[r] ? NTI / 2 : 0);
            if (row_drop[r]) begin
                en_v2t = 1'b0;    // mid-frame, partial frame must vanish
                idle_check(NTI + 2);
                bring_up();
                stream(r, 1, 0);
            end
            report_test(r + 1, row_name[r], start);
        end

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 ntests, nfailed, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+include
verilog/acore_pkg.sv
verilog/acore_sync_fsm.sv
verilog/slice_counter.sv
verilog/adc_slice.sv
verilog/frame_retimer.sv
verilog/analog_core.sv
bench/tb_clock.sv
bench/analog_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the analog core testbench with verilator
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module analog_core_tb \
    -o analog_core_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/analog_core_sim > sim.log 2>&1
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log && exit 0 || { echo "no result in log"; exit 1; }
